// ==== logic/hci_queue_pkg.sv ====
// Queue block package with widths, CSR offsets, opcodes and data types
package hci_queue_pkg;

  localparam int unsigned CsrAddrWidth    = 8;
  localparam int unsigned CsrDataWidth    = 32;
  localparam int unsigned HciCmdDataWidth = 64;
  localparam int unsigned HciThldWidth    = 8;

  typedef logic [CsrAddrWidth-1:0] csr_addr_t;

  // Also used for response entries
  typedef logic [CsrDataWidth-1:0] csr_data_t;

  typedef logic [HciCmdDataWidth-1:0] hci_cmd_t;

  typedef logic [HciThldWidth-1:0] thld_t;

  // Write-only lower command half
  localparam csr_addr_t CmdLoAddr  = 8'h00;
  // Upper command half whose write pushes the whole command
  localparam csr_addr_t CmdHiAddr  = 8'h04;
  // Read-only response pop
  localparam csr_addr_t RespAddr   = 8'h08;
  // Command threshold in [7:0] and response threshold in [15:8]
  localparam csr_addr_t ThldAddr   = 8'h0C;
  // Read-only depths and full and empty flags
  localparam csr_addr_t StatusAddr = 8'h10;

  // Status word bit positions
  localparam int unsigned StatusCmdDepthLsb  = 0;
  localparam int unsigned StatusRespDepthLsb = 8;
  localparam int unsigned StatusCmdFullBit   = 16;
  localparam int unsigned StatusCmdEmptyBit  = 17;
  localparam int unsigned StatusRespFullBit  = 18;
  localparam int unsigned StatusRespEmptyBit = 19;

  typedef enum logic [2:0] {
    OP_CMD_LO,
    OP_CMD_PUSH,
    OP_RESP_POP,
    OP_THLD_WR,
    OP_THLD_RD,
    OP_STATUS_RD,
    OP_INVALID
  } csr_op_e;

  // Both ready thresholds come out of reset at this value
  localparam thld_t ThldResetValue = 8'd1;

endpackage

// ==== logic/hci_stage_if.sv ====
// Stage interfaces csr_req_if and csr_exec_if for the CSR pipeline
interface csr_req_if;

  logic                      valid;
  hci_queue_pkg::csr_op_e    op;
  logic                      is_wr;
  hci_queue_pkg::csr_data_t  wdata;

  modport decode (
    output valid,
    output op,
    output is_wr,
    output wdata
  );

  modport execute (
    input valid,
    input op,
    input is_wr,
    input wdata
  );

endinterface

interface csr_exec_if;

  logic                      valid;
  logic                      is_wr;
  hci_queue_pkg::csr_data_t  rdata;
  logic                      err;

  modport execute (
    output valid,
    output is_wr,
    output rdata,
    output err
  );

  modport result (
    input valid,
    input is_wr,
    input rdata,
    input err
  );

endinterface

// ==== logic/hci_queue.sv ====
// Circular FIFO with depth count, full and empty flags and fall-through head
module hci_queue #(
  parameter int unsigned Depth = 8,
  parameter int unsigned Width = 32,
  localparam int unsigned DepthWidth = $clog2(Depth + 1),
  localparam int unsigned PtrWidth   = $clog2(Depth)
) (
  input  logic                  aclk,
  input  logic                  rst_n_i,
  input  logic                  push_i,
  input  logic [Width-1:0]      wdata_i,
  input  logic                  pop_i,
  output logic [Width-1:0]      rdata_o,
  output logic [DepthWidth-1:0] depth_o,
  output logic                  full_o,
  output logic                  empty_o
);

  logic [Width-1:0]      mem_q [Depth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [DepthWidth-1:0] depth_q;
  logic                  push_ok;
  logic                  pop_ok;

  // Depth need not be a power of two
  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = depth_q == DepthWidth'(Depth);
  assign empty_o = depth_q == '0;
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  always_ff @(posedge aclk) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge aclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      depth_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_ok) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Simultaneous push and pop keeps the count
      case ({push_ok, pop_ok})
        2'b10:   depth_q <= depth_q + 1'b1;
        2'b01:   depth_q <= depth_q - 1'b1;
        default: depth_q <= depth_q;
      endcase
    end
  end

  assign rdata_o = mem_q[rd_ptr_q];
  assign depth_o = depth_q;

endmodule

// ==== logic/csr_decode.sv ====
// CSR decode stage that registers a request and maps address and direction to an opcode
module csr_decode (
  input  logic                     aclk,
  input  logic                     rst_n_i,
  input  logic                     req_i,
  input  logic                     req_is_wr_i,
  input  hci_queue_pkg::csr_addr_t addr_i,
  input  hci_queue_pkg::csr_data_t wr_data_i,
  csr_req_if.decode                req_o
);

  hci_queue_pkg::csr_op_e op_d;

  // Wrong direction on a known register is treated like an unknown address
  always_comb begin
    op_d = hci_queue_pkg::OP_INVALID;
    case (addr_i)
      hci_queue_pkg::CmdLoAddr: begin
        if (req_is_wr_i) begin
          op_d = hci_queue_pkg::OP_CMD_LO;
        end
      end
      hci_queue_pkg::CmdHiAddr: begin
        if (req_is_wr_i) begin
          op_d = hci_queue_pkg::OP_CMD_PUSH;
        end
      end
      hci_queue_pkg::RespAddr: begin
        if (!req_is_wr_i) begin
          op_d = hci_queue_pkg::OP_RESP_POP;
        end
      end
      hci_queue_pkg::ThldAddr: begin
        op_d = req_is_wr_i ? hci_queue_pkg::OP_THLD_WR : hci_queue_pkg::OP_THLD_RD;
      end
      hci_queue_pkg::StatusAddr: begin
        if (!req_is_wr_i) begin
          op_d = hci_queue_pkg::OP_STATUS_RD;
        end
      end
      default: begin
        op_d = hci_queue_pkg::OP_INVALID;
      end
    endcase
  end

  always_ff @(posedge aclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_o.valid <= 1'b0;
      req_o.op    <= hci_queue_pkg::OP_INVALID;
      req_o.is_wr <= 1'b0;
    end else begin
      req_o.valid <= req_i;
      req_o.op    <= op_d;
      req_o.is_wr <= req_is_wr_i;
    end
  end

  always_ff @(posedge aclk) begin
    req_o.wdata <= wr_data_i;
  end

endmodule

// ==== logic/csr_execute.sv ====
// CSR execute stage with command assembly, both queues, thresholds and read data
module csr_execute #(
  parameter int unsigned HciCmdFifoDepth  = 8,
  parameter int unsigned HciRespFifoDepth = 8,
  localparam int unsigned CmdDepthWidth  = $clog2(HciCmdFifoDepth + 1),
  localparam int unsigned RespDepthWidth = $clog2(HciRespFifoDepth + 1)
) (
  input  logic                     aclk,
  input  logic                     rst_n_i,
  csr_req_if.execute               req_i,
  csr_exec_if.execute              exec_o,
  output logic                     hci_cmd_full_o,
  output logic                     hci_cmd_empty_o,
  output logic [CmdDepthWidth-1:0] hci_cmd_depth_o,
  output hci_queue_pkg::thld_t     hci_cmd_ready_thld_o,
  output logic                     hci_cmd_ready_thld_trig_o,
  output logic                     hci_cmd_rvalid_o,
  input  logic                     hci_cmd_rready_i,
  output hci_queue_pkg::hci_cmd_t  hci_cmd_rdata_o,
  output logic                      hci_resp_full_o,
  output logic                      hci_resp_empty_o,
  output logic [RespDepthWidth-1:0] hci_resp_depth_o,
  output hci_queue_pkg::thld_t      hci_resp_ready_thld_o,
  output logic                      hci_resp_ready_thld_trig_o,
  output logic                      hci_resp_wready_o,
  input  logic                      hci_resp_wvalid_i,
  input  hci_queue_pkg::csr_data_t  hci_resp_wdata_i
);

  localparam int unsigned TW = hci_queue_pkg::HciThldWidth;

  hci_queue_pkg::csr_data_t cmd_lo_q;
  hci_queue_pkg::csr_data_t resp_head;
  hci_queue_pkg::csr_data_t rdata_d;
  hci_queue_pkg::thld_t     cmd_thld_q;
  hci_queue_pkg::thld_t     resp_thld_q;
  logic [CmdDepthWidth-1:0] cmd_free;
  logic                     cmd_push;
  logic                     resp_pop;
  logic                     err_d;

  assign cmd_push = req_i.valid && (req_i.op == hci_queue_pkg::OP_CMD_PUSH) && !hci_cmd_full_o;
  assign resp_pop = req_i.valid && (req_i.op == hci_queue_pkg::OP_RESP_POP) && !hci_resp_empty_o;

  assign hci_cmd_rvalid_o  = !hci_cmd_empty_o;
  assign hci_resp_wready_o = !hci_resp_full_o;

  hci_queue #(
    .Depth(HciCmdFifoDepth),
    .Width(hci_queue_pkg::HciCmdDataWidth)
  ) cmd_queue_i (
    .aclk    (aclk),
    .rst_n_i (rst_n_i),
    .push_i  (cmd_push),
    .wdata_i ({req_i.wdata, cmd_lo_q}),
    .pop_i   (hci_cmd_rvalid_o && hci_cmd_rready_i),
    .rdata_o (hci_cmd_rdata_o),
    .depth_o (hci_cmd_depth_o),
    .full_o  (hci_cmd_full_o),
    .empty_o (hci_cmd_empty_o)
  );

  hci_queue #(
    .Depth(HciRespFifoDepth),
    .Width(hci_queue_pkg::CsrDataWidth)
  ) resp_queue_i (
    .aclk    (aclk),
    .rst_n_i (rst_n_i),
    .push_i  (hci_resp_wvalid_i && hci_resp_wready_o),
    .wdata_i (hci_resp_wdata_i),
    .pop_i   (resp_pop),
    .rdata_o (resp_head),
    .depth_o (hci_resp_depth_o),
    .full_o  (hci_resp_full_o),
    .empty_o (hci_resp_empty_o)
  );

  // Triggers
  assign cmd_free = CmdDepthWidth'(HciCmdFifoDepth) - hci_cmd_depth_o;
  assign hci_cmd_ready_thld_trig_o = TW'(cmd_free) >= cmd_thld_q;
  assign hci_resp_ready_thld_trig_o = (resp_thld_q != '0) &&
                                      (TW'(hci_resp_depth_o) >= resp_thld_q);
  assign hci_cmd_ready_thld_o  = cmd_thld_q;
  assign hci_resp_ready_thld_o = resp_thld_q;

  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    case (req_i.op)
      hci_queue_pkg::OP_CMD_PUSH: err_d = hci_cmd_full_o;
      hci_queue_pkg::OP_RESP_POP: begin
        err_d   = hci_resp_empty_o;
        rdata_d = hci_resp_empty_o ? '0 : resp_head;
      end
      hci_queue_pkg::OP_THLD_RD: begin
        rdata_d[TW-1:0]    = cmd_thld_q;
        rdata_d[2*TW-1:TW] = resp_thld_q;
      end
      hci_queue_pkg::OP_STATUS_RD: begin
        rdata_d[hci_queue_pkg::StatusCmdDepthLsb +: 8]  = 8'(hci_cmd_depth_o);
        rdata_d[hci_queue_pkg::StatusRespDepthLsb +: 8] = 8'(hci_resp_depth_o);
        rdata_d[hci_queue_pkg::StatusCmdFullBit]   = hci_cmd_full_o;
        rdata_d[hci_queue_pkg::StatusCmdEmptyBit]  = hci_cmd_empty_o;
        rdata_d[hci_queue_pkg::StatusRespFullBit]  = hci_resp_full_o;
        rdata_d[hci_queue_pkg::StatusRespEmptyBit] = hci_resp_empty_o;
      end
      hci_queue_pkg::OP_INVALID: err_d = 1'b1;
      default: err_d = 1'b0;
    endcase
  end

  always_ff @(posedge aclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exec_o.valid <= 1'b0;
      exec_o.is_wr <= 1'b0;
      exec_o.err   <= 1'b0;
      cmd_thld_q   <= hci_queue_pkg::ThldResetValue;
      resp_thld_q  <= hci_queue_pkg::ThldResetValue;
    end else begin
      exec_o.valid <= req_i.valid;
      exec_o.is_wr <= req_i.is_wr;
      exec_o.err   <= req_i.valid && err_d;
      if (req_i.valid && (req_i.op == hci_queue_pkg::OP_THLD_WR)) begin
        cmd_thld_q  <= req_i.wdata[TW-1:0];
        resp_thld_q <= req_i.wdata[2*TW-1:TW];
      end
    end
  end

  // Lower half survives a rejected push
  always_ff @(posedge aclk) begin
    exec_o.rdata <= rdata_d;
    if (req_i.valid && (req_i.op == hci_queue_pkg::OP_CMD_LO)) begin
      cmd_lo_q <= req_i.wdata;
    end
  end

endmodule

// ==== logic/csr_result.sv ====
// CSR result stage producing acknowledge pulses, error flags and read data
module csr_result (
  input  logic                     aclk,
  input  logic                     rst_n_i,
  csr_exec_if.result               exec_i,
  output logic                     rd_ack_o,
  output logic                     rd_err_o,
  output hci_queue_pkg::csr_data_t rd_data_o,
  output logic                     wr_ack_o,
  output logic                     wr_err_o
);

  logic rd_done;
  logic wr_done;

  assign rd_done = exec_i.valid && !exec_i.is_wr;
  assign wr_done = exec_i.valid && exec_i.is_wr;

  always_ff @(posedge aclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ack_o  <= 1'b0;
      rd_err_o  <= 1'b0;
      rd_data_o <= '0;
      wr_ack_o  <= 1'b0;
      wr_err_o  <= 1'b0;
    end else begin
      rd_ack_o <= rd_done;
      wr_ack_o <= wr_done;
      rd_err_o <= rd_done && exec_i.err;
      wr_err_o <= wr_done && exec_i.err;
      // Zero between read acks
      rd_data_o <= rd_done ? exec_i.rdata : '0;
    end
  end

endmodule

// ==== logic/hci_queue_top.sv ====
// Top level of the HCI command and response queue block
module hci_queue_top #(
  parameter int unsigned HciCmdFifoDepth  = 8,
  parameter int unsigned HciRespFifoDepth = 8,
  localparam int unsigned CmdDepthWidth  = $clog2(HciCmdFifoDepth + 1),
  localparam int unsigned RespDepthWidth = $clog2(HciRespFifoDepth + 1)
) (
  input  logic                      aclk,
  input  logic                      rst_n_i,
  // CSR side
  input  logic                      cpuif_req_i,
  input  logic                      cpuif_req_is_wr_i,
  input  hci_queue_pkg::csr_addr_t  cpuif_addr_i,
  input  hci_queue_pkg::csr_data_t  cpuif_wr_data_i,
  output logic                      cpuif_rd_ack_o,
  output logic                      cpuif_rd_err_o,
  output hci_queue_pkg::csr_data_t  cpuif_rd_data_o,
  output logic                      cpuif_wr_ack_o,
  output logic                      cpuif_wr_err_o,
  // Command queue
  output logic                      hci_cmd_full_o,
  output logic                      hci_cmd_empty_o,
  output logic [CmdDepthWidth-1:0]  hci_cmd_depth_o,
  output hci_queue_pkg::thld_t      hci_cmd_ready_thld_o,
  output logic                      hci_cmd_ready_thld_trig_o,
  output logic                      hci_cmd_rvalid_o,
  input  logic                      hci_cmd_rready_i,
  output hci_queue_pkg::hci_cmd_t   hci_cmd_rdata_o,
  // Response queue
  output logic                      hci_resp_full_o,
  output logic                      hci_resp_empty_o,
  output logic [RespDepthWidth-1:0] hci_resp_depth_o,
  output hci_queue_pkg::thld_t      hci_resp_ready_thld_o,
  output logic                      hci_resp_ready_thld_trig_o,
  output logic                      hci_resp_wready_o,
  input  logic                      hci_resp_wvalid_i,
  input  hci_queue_pkg::csr_data_t  hci_resp_wdata_i
);

  csr_req_if  req_if ();
  csr_exec_if exec_if ();

  csr_decode csr_decode_i (
    .aclk        (aclk),
    .rst_n_i     (rst_n_i),
    .req_i       (cpuif_req_i),
    .req_is_wr_i (cpuif_req_is_wr_i),
    .addr_i      (cpuif_addr_i),
    .wr_data_i   (cpuif_wr_data_i),
    .req_o       (req_if.decode)
  );

  csr_execute #(
    .HciCmdFifoDepth  (HciCmdFifoDepth),
    .HciRespFifoDepth (HciRespFifoDepth)
  ) csr_execute_i (
    .aclk                       (aclk),
    .rst_n_i                    (rst_n_i),
    .req_i                      (req_if.execute),
    .exec_o                     (exec_if.execute),
    .hci_cmd_full_o             (hci_cmd_full_o),
    .hci_cmd_empty_o            (hci_cmd_empty_o),
    .hci_cmd_depth_o            (hci_cmd_depth_o),
    .hci_cmd_ready_thld_o       (hci_cmd_ready_thld_o),
    .hci_cmd_ready_thld_trig_o  (hci_cmd_ready_thld_trig_o),
    .hci_cmd_rvalid_o           (hci_cmd_rvalid_o),
    .hci_cmd_rready_i           (hci_cmd_rready_i),
    .hci_cmd_rdata_o            (hci_cmd_rdata_o),
    .hci_resp_full_o            (hci_resp_full_o),
    .hci_resp_empty_o           (hci_resp_empty_o),
    .hci_resp_depth_o           (hci_resp_depth_o),
    .hci_resp_ready_thld_o      (hci_resp_ready_thld_o),
    .hci_resp_ready_thld_trig_o (hci_resp_ready_thld_trig_o),
    .hci_resp_wready_o          (hci_resp_wready_o),
    .hci_resp_wvalid_i          (hci_resp_wvalid_i),
    .hci_resp_wdata_i           (hci_resp_wdata_i)
  );

  csr_result csr_result_i (
    .aclk      (aclk),
    .rst_n_i   (rst_n_i),
    .exec_i    (exec_if.result),
    .rd_ack_o  (cpuif_rd_ack_o),
    .rd_err_o  (cpuif_rd_err_o),
    .rd_data_o (cpuif_rd_data_o),
    .wr_ack_o  (cpuif_wr_ack_o),
    .wr_err_o  (cpuif_wr_err_o)
  );

endmodule

// ==== verif/hci_queue_checker.sv ====
// Bound assertions on the hci_queue_top acknowledge and queue flag ports
module hci_queue_checker (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_i,
  input logic rd_ack_i,
  input logic wr_ack_i,
  input logic cmd_full_i,
  input logic cmd_empty_i,
  input logic resp_full_i,
  input logic resp_empty_i
);

  // Number of failed assertions, read by the testbench
  int unsigned fail_count = 0;

  ack_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(rd_ack_i && wr_ack_i))
    else begin
      $error("read and write acknowledge high together");
      fail_count++;
    end

  // Three edges from request to acknowledge
  req_to_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i |-> ##3 (rd_ack_i ^ wr_ack_i))
    else begin
      $error("request without a single acknowledge three edges later");
      fail_count++;
    end

  ack_from_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rd_ack_i || wr_ack_i) |-> $past(req_i, 3))
    else begin
      $error("acknowledge without a request three edges earlier");
      fail_count++;
    end

  cmd_flags: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(cmd_full_i && cmd_empty_i))
    else begin
      $error("command queue full and empty together");
      fail_count++;
    end

  resp_flags: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(resp_full_i && resp_empty_i))
    else begin
      $error("response queue full and empty together");
      fail_count++;
    end

endmodule

bind hci_queue_top hci_queue_checker hci_queue_checker_i (
  .clk_i        (aclk),
  .rst_n_i      (rst_n_i),
  .req_i        (cpuif_req_i),
  .rd_ack_i     (cpuif_rd_ack_o),
  .wr_ack_i     (cpuif_wr_ack_o),
  .cmd_full_i   (hci_cmd_full_o),
  .cmd_empty_i  (hci_cmd_empty_o),
  .resp_full_i  (hci_resp_full_o),
  .resp_empty_i (hci_resp_empty_o)
);

// ==== verif/tb_hci_queue_top.sv ====
// Table-driven testbench for hci_queue_top with compare tasks and a summary
module tb_hci_queue_top;

  typedef enum int {ROW_WR, ROW_RD, ROW_POP, ROW_PUSH, ROW_FLAGS} row_kind_e;

  // For ROW_FLAGS, data holds {cmd_trig, resp_trig, rvalid, wready} and exp_data the thresholds
  typedef struct {
    row_kind_e                kind;
    hci_queue_pkg::csr_addr_t addr;
    hci_queue_pkg::csr_data_t data;
    hci_queue_pkg::csr_data_t exp_data;
    hci_queue_pkg::hci_cmd_t  exp_cmd;
    logic                     exp_err;
  } row_t;

  localparam hci_queue_pkg::csr_addr_t CmdLo  = hci_queue_pkg::CmdLoAddr;
  localparam hci_queue_pkg::csr_addr_t CmdHi  = hci_queue_pkg::CmdHiAddr;
  localparam hci_queue_pkg::csr_addr_t Resp   = hci_queue_pkg::RespAddr;
  localparam hci_queue_pkg::csr_addr_t Thld   = hci_queue_pkg::ThldAddr;
  localparam hci_queue_pkg::csr_addr_t Status = hci_queue_pkg::StatusAddr;

  logic                     aclk;
  logic                     rst_n_i;
  logic                     cpuif_req_i;
  logic                     cpuif_req_is_wr_i;
  hci_queue_pkg::csr_addr_t cpuif_addr_i;
  hci_queue_pkg::csr_data_t cpuif_wr_data_i;
  logic                     cpuif_rd_ack_o;
  logic                     cpuif_rd_err_o;
  hci_queue_pkg::csr_data_t cpuif_rd_data_o;
  logic                     cpuif_wr_ack_o;
  logic                     cpuif_wr_err_o;
  logic                     hci_cmd_full_o;
  logic                     hci_cmd_empty_o;
  logic [3:0]               hci_cmd_depth_o;
  hci_queue_pkg::thld_t     hci_cmd_ready_thld_o;
  logic                     hci_cmd_ready_thld_trig_o;
  logic                     hci_cmd_rvalid_o;
  logic                     hci_cmd_rready_i;
  hci_queue_pkg::hci_cmd_t  hci_cmd_rdata_o;
  logic                     hci_resp_full_o;
  logic                     hci_resp_empty_o;
  logic [3:0]               hci_resp_depth_o;
  hci_queue_pkg::thld_t     hci_resp_ready_thld_o;
  logic                     hci_resp_ready_thld_trig_o;
  logic                     hci_resp_wready_o;
  logic                     hci_resp_wvalid_i;
  hci_queue_pkg::csr_data_t hci_resp_wdata_i;

  row_t table_q[$];
  int   error_count;
  int   rows_ok;
  int   rows_bad;

  hci_queue_top #(
    .HciCmdFifoDepth  (8),
    .HciRespFifoDepth (8)
  ) hci_queue_top_i (
    .aclk                       (aclk),
    .rst_n_i                    (rst_n_i),
    .cpuif_req_i                (cpuif_req_i),
    .cpuif_req_is_wr_i          (cpuif_req_is_wr_i),
    .cpuif_addr_i               (cpuif_addr_i),
    .cpuif_wr_data_i            (cpuif_wr_data_i),
    .cpuif_rd_ack_o             (cpuif_rd_ack_o),
    .cpuif_rd_err_o             (cpuif_rd_err_o),
    .cpuif_rd_data_o            (cpuif_rd_data_o),
    .cpuif_wr_ack_o             (cpuif_wr_ack_o),
    .cpuif_wr_err_o             (cpuif_wr_err_o),
    .hci_cmd_full_o             (hci_cmd_full_o),
    .hci_cmd_empty_o            (hci_cmd_empty_o),
    .hci_cmd_depth_o            (hci_cmd_depth_o),
    .hci_cmd_ready_thld_o       (hci_cmd_ready_thld_o),
    .hci_cmd_ready_thld_trig_o  (hci_cmd_ready_thld_trig_o),
    .hci_cmd_rvalid_o           (hci_cmd_rvalid_o),
    .hci_cmd_rready_i           (hci_cmd_rready_i),
    .hci_cmd_rdata_o            (hci_cmd_rdata_o),
    .hci_resp_full_o            (hci_resp_full_o),
    .hci_resp_empty_o           (hci_resp_empty_o),
    .hci_resp_depth_o           (hci_resp_depth_o),
    .hci_resp_ready_thld_o      (hci_resp_ready_thld_o),
    .hci_resp_ready_thld_trig_o (hci_resp_ready_thld_trig_o),
    .hci_resp_wready_o          (hci_resp_wready_o),
    .hci_resp_wvalid_i          (hci_resp_wvalid_i),
    .hci_resp_wdata_i           (hci_resp_wdata_i)
  );

  always #10 aclk = ~aclk;

  function automatic void wr_row(hci_queue_pkg::csr_addr_t addr, hci_queue_pkg::csr_data_t data,
                                 logic exp_err);
    table_q.push_back('{ROW_WR, addr, data, '0, '0, exp_err});
  endfunction

  function automatic void rd_row(hci_queue_pkg::csr_addr_t addr,
                                 hci_queue_pkg::csr_data_t exp_data, logic exp_err);
    table_q.push_back('{ROW_RD, addr, '0, exp_data, '0, exp_err});
  endfunction

  function automatic void pop_row(hci_queue_pkg::hci_cmd_t exp_cmd);
    table_q.push_back('{ROW_POP, '0, '0, '0, exp_cmd, 1'b0});
  endfunction

  function automatic void push_row(hci_queue_pkg::csr_data_t data);
    table_q.push_back('{ROW_PUSH, '0, data, '0, '0, 1'b0});
  endfunction

  function automatic void flags_row(logic [3:0] flags, hci_queue_pkg::csr_data_t thld);
    table_q.push_back('{ROW_FLAGS, '0, {28'h0, flags}, thld, '0, 1'b0});
  endfunction

  // Lower half first and then the pushing upper half
  function automatic void cmd_rows(hci_queue_pkg::hci_cmd_t cmd, logic hi_err);
    wr_row(CmdLo, cmd[31:0], 1'b0);
    wr_row(CmdHi, cmd[63:32], hi_err);
  endfunction

  function automatic hci_queue_pkg::hci_cmd_t random_cmd();
    return {$urandom(), $urandom()};
  endfunction

  task automatic build_table();
    hci_queue_pkg::hci_cmd_t  cmds [8];
    hci_queue_pkg::csr_data_t resp [3];
    int                       i;
    // Reset state
    rd_row(Status, 32'h000A_0000, 1'b0);
    rd_row(Thld, 32'h0000_0101, 1'b0);
    flags_row(4'b1001, 32'h0000_0101);
    // Command path
    for (i = 0; i < 2; i++) begin
      cmds[i] = random_cmd();
      cmd_rows(cmds[i], 1'b0);
    end
    rd_row(Status, 32'h0008_0002, 1'b0);
    for (i = 0; i < 2; i++) begin
      pop_row(cmds[i]);
    end
    rd_row(Status, 32'h000A_0000, 1'b0);
    // Response path
    for (i = 0; i < 2; i++) begin
      resp[i] = $urandom();
      push_row(resp[i]);
    end
    rd_row(Status, 32'h0002_0200, 1'b0);
    rd_row(Resp, resp[0], 1'b0);
    rd_row(Resp, resp[1], 1'b0);
    rd_row(Resp, 32'h0, 1'b1);
    // Full command queue with a rejected ninth push
    for (i = 0; i < 8; i++) begin
      cmds[i] = random_cmd();
      cmd_rows(cmds[i], 1'b0);
    end
    flags_row(4'b0011, 32'h0000_0101);
    rd_row(Status, 32'h0009_0008, 1'b0);
    cmd_rows(random_cmd(), 1'b1);
    for (i = 0; i < 8; i++) begin
      pop_row(cmds[i]);
    end
    flags_row(4'b1001, 32'h0000_0101);
    // Thresholds
    wr_row(Thld, 32'h0000_0302, 1'b0);
    rd_row(Thld, 32'h0000_0302, 1'b0);
    flags_row(4'b1001, 32'h0000_0302);
    for (i = 0; i < 3; i++) begin
      resp[i] = $urandom();
      push_row(resp[i]);
      flags_row((i == 2) ? 4'b1101 : 4'b1001, 32'h0000_0302);
    end
    for (i = 0; i < 3; i++) begin
      rd_row(Resp, resp[i], 1'b0);
    end
    for (i = 0; i < 7; i++) begin
      cmds[i] = random_cmd();
      cmd_rows(cmds[i], 1'b0);
      // Free entries fall below 2 at the seventh command
      flags_row((i == 6) ? 4'b0011 : 4'b1011, 32'h0000_0302);
    end
    for (i = 0; i < 7; i++) begin
      pop_row(cmds[i]);
    end
    // Invalid accesses
    rd_row(CmdLo, 32'h0, 1'b1);
    wr_row(Status, $urandom(), 1'b1);
    rd_row(8'h20, 32'h0, 1'b1);
    wr_row(8'h20, $urandom(), 1'b1);
    rd_row(Status, 32'h000A_0000, 1'b0);
  endtask

  task automatic check_data(string name, hci_queue_pkg::csr_data_t got,
                            hci_queue_pkg::csr_data_t exp);
    if (got !== exp) begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_cmd(string name, hci_queue_pkg::hci_cmd_t got,
                           hci_queue_pkg::hci_cmd_t exp);
    if (got !== exp) begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // Queue depth and flag ports against the fields of the expected status word
  task automatic status_port_compare(input hci_queue_pkg::csr_data_t exp);
    check_data("hci_cmd_depth_o", 32'(hci_cmd_depth_o), {24'h0, exp[7:0]});
    check_data("hci_resp_depth_o", 32'(hci_resp_depth_o), {24'h0, exp[15:8]});
    check_flag("hci_cmd_full_o", hci_cmd_full_o, exp[16]);
    check_flag("hci_cmd_empty_o", hci_cmd_empty_o, exp[17]);
    check_flag("hci_resp_full_o", hci_resp_full_o, exp[18]);
    check_flag("hci_resp_empty_o", hci_resp_empty_o, exp[19]);
  endtask

  task automatic csr_access(input row_t r, input int idx);
    int   cycles;
    logic is_wr;
    logic got;
    is_wr = (r.kind == ROW_WR);
    @(posedge aclk);
    #2;
    cpuif_req_i       = 1'b1;
    cpuif_req_is_wr_i = is_wr;
    cpuif_addr_i      = r.addr;
    cpuif_wr_data_i   = r.data;
    @(posedge aclk);
    #2;
    cpuif_req_i = 1'b0;
    got         = 1'b0;
    cycles      = 0;
    while (!got && cycles < 10) begin
      @(negedge aclk);
      cycles++;
      got = is_wr ? cpuif_wr_ack_o : cpuif_rd_ack_o;
    end
    if (!got) begin
      $display("row %0d: no acknowledge within 10 cycles", idx);
      error_count++;
    end else if (is_wr) begin
      check_flag("cpuif_wr_err_o", cpuif_wr_err_o, r.exp_err);
    end else begin
      check_flag("cpuif_rd_err_o", cpuif_rd_err_o, r.exp_err);
      check_data("cpuif_rd_data_o", cpuif_rd_data_o, r.exp_data);
      if (r.addr == Status) begin
        status_port_compare(r.exp_data);
      end
    end
  endtask

  task automatic fsm_access(input row_t r, input int idx);
    int cycles;
    cycles = 0;
    @(posedge aclk);
    #2;
    while (((r.kind == ROW_POP) ? !hci_cmd_rvalid_o : !hci_resp_wready_o) && cycles < 10) begin
      @(posedge aclk);
      #2;
      cycles++;
    end
    if (cycles >= 10) begin
      $display("row %0d: queue handshake not ready within 10 cycles", idx);
      error_count++;
    end else if (r.kind == ROW_POP) begin
      check_cmd("hci_cmd_rdata_o", hci_cmd_rdata_o, r.exp_cmd);
      hci_cmd_rready_i = 1'b1;
      @(posedge aclk);
      #2;
      hci_cmd_rready_i = 1'b0;
    end else begin
      hci_resp_wvalid_i = 1'b1;
      hci_resp_wdata_i  = r.data;
      @(posedge aclk);
      #2;
      hci_resp_wvalid_i = 1'b0;
    end
  endtask

  task automatic flags_sample(input row_t r);
    @(negedge aclk);
    check_flag("hci_cmd_ready_thld_trig_o", hci_cmd_ready_thld_trig_o, r.data[3]);
    check_flag("hci_resp_ready_thld_trig_o", hci_resp_ready_thld_trig_o, r.data[2]);
    check_flag("hci_cmd_rvalid_o", hci_cmd_rvalid_o, r.data[1]);
    check_flag("hci_resp_wready_o", hci_resp_wready_o, r.data[0]);
    check_data("hci_cmd_ready_thld_o", {24'h0, hci_cmd_ready_thld_o}, {24'h0, r.exp_data[7:0]});
    check_data("hci_resp_ready_thld_o", {24'h0, hci_resp_ready_thld_o},
               {24'h0, r.exp_data[15:8]});
  endtask

  initial begin
    int errors_before;
    aclk              = 1'b0;
    rst_n_i           = 1'b0;
    cpuif_req_i       = 1'b0;
    cpuif_req_is_wr_i = 1'b0;
    cpuif_addr_i      = '0;
    cpuif_wr_data_i   = '0;
    hci_cmd_rready_i  = 1'b0;
    hci_resp_wvalid_i = 1'b0;
    hci_resp_wdata_i  = '0;
    error_count       = 0;
    rows_ok           = 0;
    rows_bad          = 0;
    void'($urandom(32'hda8b_7147));
    build_table();
    repeat (16) @(posedge aclk);
    #2;
    rst_n_i = 1'b1;
    foreach (table_q[idx]) begin
      errors_before = error_count;
      case (table_q[idx].kind)
        ROW_WR, ROW_RD: csr_access(table_q[idx], idx);
        ROW_POP, ROW_PUSH: fsm_access(table_q[idx], idx);
        default: flags_sample(table_q[idx]);
      endcase
      if (error_count == errors_before) begin
        rows_ok++;
      end else begin
        rows_bad++;
      end
      $display("row %0d %s addr %h: %s", idx, table_q[idx].kind.name(), table_q[idx].addr,
               (error_count == errors_before) ? "ok" : "mismatch");
    end
    if (hci_queue_top_i.hci_queue_checker_i.fail_count != 0) begin
      $display("bound checker assertions failed %0d times",
               hci_queue_top_i.hci_queue_checker_i.fail_count);
      error_count += hci_queue_top_i.hci_queue_checker_i.fail_count;
    end
    $display("rows ok %0d, rows with errors %0d, errors %0d", rows_ok, rows_bad, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
logic/hci_queue_pkg.sv
logic/hci_stage_if.sv
logic/hci_queue.sv
logic/csr_decode.sv
logic/csr_execute.sv
logic/csr_result.sv
logic/hci_queue_top.sv
verif/hci_queue_checker.sv
verif/tb_hci_queue_top.sv

// ==== Bender.yml ====
package:
  name: hci_queue

sources:
  - files:
      - logic/hci_queue_pkg.sv
      - logic/hci_stage_if.sv
      - logic/hci_queue.sv
      - logic/csr_decode.sv
      - logic/csr_execute.sv
      - logic/csr_result.sv
      - logic/hci_queue_top.sv
  - target: test
    files:
      - verif/hci_queue_checker.sv
      - verif/tb_hci_queue_top.sv
